/* verilog/mlnn_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared sizes of the layer-multiplexed network
// per-layer neuron counts, fixed weight and bias tables
//////////////////////////////////////////////////////////////////////
`default_nettype none

package mlnn_pkg;

    // physical neurons, also the length of every input vector
    localparam int num_neuron  = 6;
    // logical layers run on the one physical layer
    localparam int layer_max   = 3;
    // holds 0 through layer_max
    localparam int layer_bits  = $clog2(layer_max + 1);
    // input index within a layer
    localparam int step_bits   = $clog2(num_neuron);

    localparam int input_size  = 9;
    localparam int weight_size = 8;
    localparam int acc_size    = 20;
    localparam int act_max     = (1 << input_size) - 1;

    // cycles from layer start to result valid
    localparam int layer_latency = num_neuron + 1;

    // neurons active per logical layer
    localparam int layer_width [layer_max] = '{6, 4, 3};

    //////////////////////////////////////////////////////////////////////
    // weights, indexed [layer][neuron][input]
    //////////////////////////////////////////////////////////////////////
    localparam logic signed [weight_size-1:0] weight_table
        [layer_max][num_neuron][num_neuron] = '{
        '{'{ 1,  2, -1,  0,  1, -2},
          '{-3,  1,  2,  1,  0,  1},
          '{ 2, -1,  1, -2,  3,  0},
          '{ 0,  1,  1,  1, -1, -1},
          '{ 1,  0, -2,  2,  1,  1},
          '{-1, -1,  0,  3,  2, -1}},
        // layer 1, neurons 4 and 5 unused
        '{'{ 1, -1,  0,  1,  0,  1},
          '{ 0,  1,  1, -1,  1,  0},
          '{-1,  0,  2,  0,  1, -1},
          '{ 1,  1, -1,  0, -1,  1},
          '{ 0,  0,  0,  0,  0,  0},
          '{ 0,  0,  0,  0,  0,  0}},
        // layer 2, only inputs 0 to 3 carry data
        '{'{ 2, -1,  1,  0,  0,  0},
          '{-1,  1,  0,  1,  0,  0},
          '{ 1,  1,  1, -2,  0,  0},
          '{ 0,  0,  0,  0,  0,  0},
          '{ 0,  0,  0,  0,  0,  0},
          '{ 0,  0,  0,  0,  0,  0}}
    };

    // biases, indexed [layer][neuron]
    localparam logic signed [weight_size-1:0] bias_table [layer_max][num_neuron] = '{
        '{10, -20,  5,   0, 15, -8},
        '{-5,  12,  3, -16,  0,  0},
        '{ 7,  -3,  0,   0,  0,  0}
    };

endpackage

`default_nettype wire

/* verilog/input_aggregator.sv */
//////////////////////////////////////////////////////////////////////
// input aggregator
// captures the start vector, picks the layer inputs and active mask
// and fires the layer start strobe
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module input_aggregator (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  start,
    input  logic [mlnn_pkg::num_neuron*mlnn_pkg::input_size-1:0] start_input,
    input  logic [mlnn_pkg::layer_bits-1:0]                       layer,
    input  logic                                                  busy,
    input  logic [mlnn_pkg::num_neuron*mlnn_pkg::input_size-1:0] layer_input,
    input  logic [mlnn_pkg::num_neuron-1:0]                       layer_input_valid,
    output logic [mlnn_pkg::num_neuron*mlnn_pkg::input_size-1:0] out_inputs,
    output logic [mlnn_pkg::num_neuron-1:0]                       active,
    output logic                                                  layer_start
);

    import mlnn_pkg::*;

    typedef enum logic {
        st_idle,
        st_wait
    } state_t;

    state_t state;

    // outside vector, held for the whole of layer 0
    logic [num_neuron*input_size-1:0] start_reg;

    // all neurons of the current layer have reported
    logic layer_done;

    //////////////////////////////////////////////////////////////////////
    // active mask from the layer width table
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        active = '0;
        if (layer < layer_bits'(layer_max)) begin
            for (int i = 0; i < num_neuron; i++) begin
                active[i] = (i < layer_width[layer]);
            end
        end
    end

    assign layer_done = ((layer_input_valid & active) == active);

    // layer 0 reads the outside vector, later layers the feedback
    assign out_inputs = (layer == '0) ? start_reg : layer_input;

    //////////////////////////////////////////////////////////////////////
    // idle / wait fsm
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            layer_start <= 1'b0;
        end else begin
            layer_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (start && !busy) begin
                        state       <= st_wait;
                        layer_start <= 1'b1;
                    end
                end
                st_wait: begin
                    // last layer counted, busy already low
                    if (layer >= layer_bits'(layer_max)) begin
                        if (start && !busy) begin
                            // next run starts in the output strobe cycle
                            layer_start <= 1'b1;
                        end else begin
                            state <= st_idle;
                        end
                    end else if (!layer_start && layer_done) begin
                        // valid bits still set in the strobe cycle, hence the guard
                        layer_start <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // capture of the start vector, busy is low only between runs
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            start_reg <= start_input;
        end
    end

endmodule

`default_nettype wire

/* verilog/neuron.sv */
//////////////////////////////////////////////////////////////////////
// one serial multiply-accumulate neuron
// bias preload, relu and saturation at act_max
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module neuron (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     clear,
    input  logic                                     enable,
    input  logic        [mlnn_pkg::input_size-1:0]   x,
    input  logic signed [mlnn_pkg::weight_size-1:0]  w,
    input  logic signed [mlnn_pkg::weight_size-1:0]  bias,
    input  logic                                     finish,
    output logic        [mlnn_pkg::input_size-1:0]   y
);

    import mlnn_pkg::*;

    logic signed [acc_size-1:0] acc;
    logic signed [acc_size-1:0] product;
    logic signed [acc_size-1:0] acc_next;

    // activation is unsigned, zero extend before the signed multiply
    assign product  = $signed({1'b0, x}) * w;
    assign acc_next = enable ? acc + product : acc;

    // accumulator
    always_ff @(posedge clk) begin
        if (clear) begin
            // sign extended bias as the starting sum
            acc <= bias;
        end else if (enable) begin
            acc <= acc_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // relu with saturation
    //////////////////////////////////////////////////////////////////////
    // finish comes with the last product, so the clamp sees acc_next
    always_ff @(posedge clk) begin
        if (rst) begin
            y <= '0;
        end else if (finish) begin
            if (acc_next < 0) begin
                y <= '0;
            end else if (acc_next > act_max) begin
                y <= input_size'(act_max);
            end else begin
                y <= acc_next[input_size-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/neuron_layer.sv */
//////////////////////////////////////////////////////////////////////
// physical neuron layer
// input step sequencer, weight and bias lookup, neuron array
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module neuron_layer (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  layer_start,
    input  logic [mlnn_pkg::layer_bits-1:0]                       layer,
    input  logic [mlnn_pkg::num_neuron-1:0]                       active,
    input  logic [mlnn_pkg::num_neuron*mlnn_pkg::input_size-1:0] inputs,
    output logic [mlnn_pkg::num_neuron*mlnn_pkg::input_size-1:0] result,
    output logic                                                  result_valid
);

    import mlnn_pkg::*;

    // sequencer state
    logic                  running;
    logic [step_bits-1:0]  step;
    logic                  last_step;

    // table row of the current layer, held in range once all layers are done
    logic [layer_bits-1:0] layer_sel;

    // input shared by all neurons this cycle
    logic [input_size-1:0] x_cur;

    assign layer_sel = (layer < layer_bits'(layer_max)) ? layer : '0;
    assign last_step = running && (step == step_bits'(num_neuron - 1));
    assign x_cur     = inputs[step*input_size +: input_size];

    //////////////////////////////////////////////////////////////////////
    // step counter
    //////////////////////////////////////////////////////////////////////
    // input k is on the lanes in cycle t+1+k
    always_ff @(posedge clk) begin
        if (rst) begin
            running      <= 1'b0;
            step         <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= last_step;
            if (layer_start) begin
                running <= 1'b1;
                step    <= '0;
            end else if (last_step) begin
                running <= 1'b0;
                step    <= '0;
            end else if (running) begin
                step <= step + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // neuron array
    //////////////////////////////////////////////////////////////////////
    for (genvar n = 0; n < num_neuron; n++) begin : g_lane
        logic [input_size-1:0] y;

        neuron u_neuron (
            .clk    (clk),
            .rst    (rst),
            .clear  (layer_start),
            .enable (running),
            .x      (x_cur),
            .w      (weight_table[layer_sel][n][step]),
            .bias   (bias_table[layer_sel][n]),
            .finish (last_step),
            .y      (y)
        );

        // unused neurons of this layer report zero
        assign result[n*input_size +: input_size] = active[n] ? y : '0;
    end

endmodule

`default_nettype wire

/* verilog/output_aggregator.sv */
//////////////////////////////////////////////////////////////////////
// output aggregator
// holds the latest layer results and their valid bits for feedback
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module output_aggregator (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  layer_start,
    input  logic [mlnn_pkg::num_neuron*mlnn_pkg::input_size-1:0] result,
    input  logic                                                  result_valid,
    input  logic [mlnn_pkg::num_neuron-1:0]                       active,
    output logic [mlnn_pkg::num_neuron*mlnn_pkg::input_size-1:0] layer_input,
    output logic [mlnn_pkg::num_neuron-1:0]                       layer_input_valid
);

    import mlnn_pkg::*;

    logic [num_neuron-1:0] valid_bits;

    // per-neuron valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (layer_start) begin
            // new layer under way, old results no longer count
            valid_bits <= '0;
        end else if (result_valid) begin
            valid_bits <= valid_bits | active;
        end
    end

    // result register, next layer's input
    always_ff @(posedge clk) begin
        if (result_valid) begin
            layer_input <= result;
        end
    end

    assign layer_input_valid = valid_bits;

endmodule

`default_nettype wire

/* verilog/layer_controller.sv */
//////////////////////////////////////////////////////////////////////
// layer controller
// completed layer count, busy flag and the final output strobe
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module layer_controller (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  start,
    input  logic                                                  result_valid,
    input  logic [mlnn_pkg::num_neuron*mlnn_pkg::input_size-1:0] result,
    output logic [mlnn_pkg::layer_bits-1:0]                       layer,
    output logic                                                  busy,
    output logic                                                  out_valid,
    output logic [mlnn_pkg::num_neuron*mlnn_pkg::input_size-1:0] out_activations
);

    import mlnn_pkg::*;

    // result of the last logical layer arriving now
    logic final_result;

    assign final_result = busy && result_valid &&
                          (layer == layer_bits'(layer_max - 1));

    //////////////////////////////////////////////////////////////////////
    // layer count and busy
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            layer     <= '0;
            busy      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (start && !busy) begin
                // new run, layer 0 again
                busy  <= 1'b1;
                layer <= '0;
            end else if (busy && result_valid) begin
                layer <= layer + 1'b1;
                if (final_result) begin
                    out_valid <= 1'b1;
                    busy      <= 1'b0;
                end
            end
        end
    end

    // output activations, valid alongside out_valid
    always_ff @(posedge clk) begin
        if (final_result) begin
            out_activations <= result;
        end
    end

endmodule

`default_nettype wire

/* verilog/mlnn_top.sv */
//////////////////////////////////////////////////////////////////////
// top level of the layer-multiplexed network
// input aggregator, neuron layer, output aggregator, layer controller
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mlnn_top (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  start,
    input  logic [mlnn_pkg::num_neuron*mlnn_pkg::input_size-1:0] start_input,
    output logic                                                  busy,
    output logic                                                  out_valid,
    output logic [mlnn_pkg::num_neuron*mlnn_pkg::input_size-1:0] out_activations
);

    import mlnn_pkg::*;

    // aggregator to layer
    logic [num_neuron*input_size-1:0] layer_inputs;
    logic [num_neuron-1:0]            active;
    logic                             layer_start;

    // layer results
    logic [num_neuron*input_size-1:0] result;
    logic                             result_valid;

    // feedback path
    logic [num_neuron*input_size-1:0] layer_input;
    logic [num_neuron-1:0]            layer_input_valid;

    // completed layer count
    logic [layer_bits-1:0]            layer;

    input_aggregator u_input_aggregator (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .start_input       (start_input),
        .layer             (layer),
        .busy              (busy),
        .layer_input       (layer_input),
        .layer_input_valid (layer_input_valid),
        .out_inputs        (layer_inputs),
        .active            (active),
        .layer_start       (layer_start)
    );

    neuron_layer u_neuron_layer (
        .clk          (clk),
        .rst          (rst),
        .layer_start  (layer_start),
        .layer        (layer),
        .active       (active),
        .inputs       (layer_inputs),
        .result       (result),
        .result_valid (result_valid)
    );

    output_aggregator u_output_aggregator (
        .clk               (clk),
        .rst               (rst),
        .layer_start       (layer_start),
        .result            (result),
        .result_valid      (result_valid),
        .active            (active),
        .layer_input       (layer_input),
        .layer_input_valid (layer_input_valid)
    );

    layer_controller u_layer_controller (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .result_valid    (result_valid),
        .result          (result),
        .layer           (layer),
        .busy            (busy),
        .out_valid       (out_valid),
        .out_activations (out_activations)
    );

endmodule

`default_nettype wire

/* verification/mlnn_sva.sv */
//////////////////////////////////////////////////////////////////////
// concurrent assertions on layer handshake and output strobe
// bound into mlnn_top
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mlnn_sva (
    input logic clk,
    input logic rst,
    input logic layer_start,
    input logic result_valid,
    input logic out_valid
);

    import mlnn_pkg::*;

    // layer_start over the last layer_latency+1 cycles, bit 0 most recent
    logic [layer_latency:0] start_hist;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_hist <= '0;
        end else begin
            start_hist <= {start_hist[layer_latency-1:0], layer_start};
        end
    end

    // next layer only after the previous results are counted
    a_layer_spacing: assert property (
        @(posedge clk) disable iff (rst)
        layer_start |-> (start_hist == '0)
    ) else $error("layer start while the previous layer is still in flight");

    //////////////////////////////////////////////////////////////////////
    // layer latency in both directions
    //////////////////////////////////////////////////////////////////////
    a_result_after_start: assert property (
        @(posedge clk) disable iff (rst)
        $past(layer_start, layer_latency) |-> result_valid
    ) else $error("result_valid missing after layer start");

    a_result_has_start: assert property (
        @(posedge clk) disable iff (rst)
        result_valid |-> $past(layer_start, layer_latency)
    ) else $error("result_valid without matching layer start");

    // single cycle output strobe
    a_out_strobe: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |=> !out_valid
    ) else $error("out_valid high for more than one cycle");

endmodule

bind mlnn_top mlnn_sva u_mlnn_sva (
    .clk          (clk),
    .rst          (rst),
    .layer_start  (layer_start),
    .result_valid (result_valid),
    .out_valid    (out_valid)
);

`default_nettype wire

/* verification/mlnn_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the layer-multiplexed network
// trace driven stimulus, output checks and cycle timeout
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mlnn_tb;

    import mlnn_pkg::*;

    localparam int num_vectors = 8;
    // six inputs then six expected outputs per trace line
    localparam int trace_cols  = 2 * num_neuron;
    // edges from the start sample to out_valid
    localparam int end_latency = 26;
    localparam int cycle_limit = num_vectors * 40;
    localparam int vec_bits    = num_neuron * input_size;

    logic                clk = 1'b0;
    logic                rst;
    logic                start;
    logic [vec_bits-1:0] start_input;
    logic                busy;
    logic                out_valid;
    logic [vec_bits-1:0] out_activations;

    logic [input_size-1:0] trace_mem [num_vectors*trace_cols];
    int                    cycle_count = 0;
    int                    rand_seed = 11949;

    mlnn_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .start_input     (start_input),
        .busy            (busy),
        .out_valid       (out_valid),
        .out_activations (out_activations)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            fail_run($sformatf("mismatch at time %0t: %s, got %0d, expected %0d",
                               $time, what, got, want));
        end
    endtask

    // whole run bound
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run($sformatf("timeout, run still going after %0d cycles", cycle_count));
        end
    end

    // one trace line packed into a vector, first picks inputs or expected
    function automatic logic [vec_bits-1:0] trace_vector(input int v, input int first);
        logic [vec_bits-1:0] vec;
        for (int n = 0; n < num_neuron; n++) begin
            vec[n*input_size +: input_size] = trace_mem[v*trace_cols + first + n];
        end
        return vec;
    endfunction

    // quiet cycles with noise on the data input
    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            start_input <= vec_bits'({$urandom, $urandom});
            @(negedge clk);
            check_value(busy, 0, "busy while idle");
            check_value(out_valid, 0, "out_valid while idle");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one vector through all three layers
    //////////////////////////////////////////////////////////////////////
    task automatic run_vector(input int v, input bit poke_busy);
        logic [vec_bits-1:0] expect_out;
        int                  cyc;
        bit                  seen;
        expect_out = trace_vector(v, num_neuron);
        cyc        = 0;
        seen       = 1'b0;
        @(posedge clk);
        start       <= 1'b1;
        start_input <= trace_vector(v, 0);
        // strobe of the vector before is gone by now
        @(negedge clk);
        check_value(out_valid, 0, "out_valid longer than one cycle");
        check_value(busy, 0, "busy before start");
        while (!seen) begin
            @(posedge clk);
            // second start mid run, has to be ignored
            start       <= poke_busy && (cyc == 9);
            start_input <= vec_bits'({$urandom, $urandom});
            @(negedge clk);
            if (out_valid) begin
                seen = 1'b1;
            end else begin
                check_value(busy, 1, $sformatf("vector %0d busy during run", v));
                cyc++;
                if (cyc > end_latency + 4) begin
                    fail_run($sformatf("vector %0d never raised out_valid", v));
                end
            end
        end
        check_value(cyc, end_latency, $sformatf("vector %0d start to out_valid", v));
        check_value(busy, 0, $sformatf("vector %0d busy with out_valid", v));
        for (int n = 0; n < num_neuron; n++) begin
            check_value(out_activations[n*input_size +: input_size],
                        expect_out[n*input_size +: input_size],
                        $sformatf("vector %0d lane %0d", v, n));
            // unused neurons of the last layer
            if (n >= layer_width[layer_max-1]) begin
                check_value(out_activations[n*input_size +: input_size], 0,
                            $sformatf("vector %0d inactive lane %0d", v, n));
            end
        end
    endtask

    initial begin
        int gap;
        // seed once for the whole run
        gap         = $urandom(rand_seed);
        rst         = 1'b1;
        start       = 1'b0;
        start_input = '0;
        $readmemh("verification/mlnn_trace.txt", trace_mem);
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        idle_cycles(4);
        for (int v = 0; v < num_vectors; v++) begin
            run_vector(v, v == 2);
            // odd vectors go straight into the next start
            gap = (v % 2 == 1) ? 0 : $urandom_range(1, 6);
            idle_cycles(gap);
        end
        idle_cycles(3);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/mlnn_trace.txt */
// columns: in0 in1 in2 in3 in4 in5 then exp0 exp1 exp2 exp3 exp4 exp5
// 9-bit hex activations, lane 0 first, exp3 to exp5 belong to unused final neurons
// all zero, biases only
000 000 000 000 000 000  003 018 037 000 000 000
// small ramp
001 002 003 004 005 006  00d 030 071 000 000 000
// larger ramp, lane 0 below zero and lane 2 clipped, also gets the mid-run start
00a 014 01e 028 032 03c  000 18f 1ff 000 000 000
// every input at act_max
1ff 1ff 1ff 1ff 1ff 1ff  1ff 1ec 1ff 000 000 000
// input 0 only
0c8 000 000 000 000 000  1a1 12f 1ff 000 000 000
// input 5 only
000 000 000 000 000 12c  000 1fc 1ff 000 000 000
// input 3 only
000 000 000 064 000 000  1b2 026 0de 000 000 000
// inputs 0 and 1
032 064 000 000 000 000  1ff 000 007 000 000 000

/* files.f */
verilog/mlnn_pkg.sv
verilog/input_aggregator.sv
verilog/neuron.sv
verilog/neuron_layer.sv
verilog/output_aggregator.sv
verilog/layer_controller.sv
verilog/mlnn_top.sv
verification/mlnn_sva.sv
verification/mlnn_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator and run it, the exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module mlnn_tb -f files.f -o mlnn_sim &&
./obj_dir/mlnn_sim || exit 1
